// ==== Bender.yml ====
package:
  name: pdp8

sources:
  - pdp8_pkg.sv
  - pdp8_ram.sv
  - pdp8_mem_addr.sv
  - pdp8_state_seq.sv
  - pdp8_regs.sv
  - pdp8_core.sv
  - target: test
    files:
      - pdp8_assertions.sv
      - pdp8_tb.sv

// ==== filelist.f ====
pdp8_pkg.sv
pdp8_ram.sv
pdp8_mem_addr.sv
pdp8_state_seq.sv
pdp8_regs.sv
pdp8_core.sv
pdp8_assertions.sv
pdp8_tb.sv

// ==== pdp8_assertions.sv ====
`default_nettype none

module pdp8_assertions
    import pdp8_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 reset,
    input wire major_state_t         state,
    input wire logic                 running,
    input wire logic [WORD_BITS-1:0] ma
);

    int fail_count = 0;   // read by the testbench

    // last state of each phase may branch, the rest just count up
    function automatic logic legal_step(input major_state_t cur, input major_state_t nxt);
        case (cur)
            F3:      return nxt inside {D0, E0, F0, H0};
            D3:      return nxt inside {E0, F0, H0};
            E3:      return nxt inside {F0, H0};
            H3:      return nxt inside {F0, H0};
            default: return nxt == major_state_t'(cur + 5'd1);
        endcase
    endfunction

    state_order: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> legal_step($past(state), state))
    else
    begin
        $error("major state stepped out of order");
        fail_count++;
    end

    halt_not_running: assert property (@(posedge clk) disable iff (reset)
        state inside {H0, H1, H2, H3} |-> !running)
    else
    begin
        $error("running high in a halt state");
        fail_count++;
    end

    ma_held_in_fetch: assert property (@(posedge clk) disable iff (reset)
        state inside {F1, F2} |=> $stable(ma))
    else
    begin
        $error("ma changed after F0 during fetch");
        fail_count++;
    end

    reset_to_h0: assert property (@(posedge clk) reset |=> state == H0)
    else
    begin
        $error("state not H0 after reset");
        fail_count++;
    end

endmodule

bind pdp8_core pdp8_assertions core_checks (
    .clk     (clk),
    .reset   (reset),
    .state   (state),
    .running (running),
    .ma      (ma)
);

`default_nettype wire

// ==== pdp8_core.sv ====
`default_nettype none

module pdp8_core
    import pdp8_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [WORD_BITS-1:0] sr,
    input  wire logic                 load_addr,
    input  wire logic                 deposit,
    input  wire logic                 examine,
    input  wire logic                 run,
    input  wire logic                 halt,
    output wire logic [WORD_BITS-1:0] pc,
    output wire logic [WORD_BITS-1:0] ac,
    output wire logic                 link,
    output wire logic [WORD_BITS-1:0] ma,
    output wire logic [WORD_BITS-1:0] mdout,
    output wire major_state_t         state,
    output wire logic                 running
);

    wire logic [WORD_BITS-1:0] instruction;
    wire logic                 isz_skip;
    wire logic                 halt_req;
    wire logic                 panel_load;
    wire logic                 panel_deposit;
    wire logic                 panel_examine;

    pdp8_state_seq seq (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .run           (run),
        .halt          (halt),
        .halt_req      (halt_req),
        .load_addr     (load_addr),
        .deposit       (deposit),
        .examine       (examine),
        .state         (state),
        .running       (running),
        .panel_load    (panel_load),
        .panel_deposit (panel_deposit),
        .panel_examine (panel_examine)
    );

    pdp8_mem_addr mau (
        .clk           (clk),
        .reset         (reset),
        .state         (state),
        .pc            (pc),
        .ac            (ac),
        .sr            (sr),
        .panel_load    (panel_load),
        .panel_deposit (panel_deposit),
        .panel_examine (panel_examine),
        .instruction   (instruction),
        .ma            (ma),
        .mdout         (mdout),
        .isz_skip      (isz_skip)
    );

    pdp8_regs regs (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .instruction (instruction),
        .mdout       (mdout),
        .ma          (ma),
        .isz_skip    (isz_skip),
        .sr          (sr),
        .panel_load  (panel_load),
        .pc          (pc),
        .ac          (ac),
        .link        (link),
        .halt_req    (halt_req)
    );

endmodule

`default_nettype wire

// ==== pdp8_mem_addr.sv ====
`default_nettype none

module pdp8_mem_addr
    import pdp8_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire major_state_t         state,
    input  wire logic [WORD_BITS-1:0] pc,
    input  wire logic [WORD_BITS-1:0] ac,
    input  wire logic [WORD_BITS-1:0] sr,
    input  wire logic                 panel_load,
    input  wire logic                 panel_deposit,
    input  wire logic                 panel_examine,
    output logic      [WORD_BITS-1:0] instruction,
    output logic      [WORD_BITS-1:0] ma,
    output wire logic [WORD_BITS-1:0] mdout,
    output logic                      isz_skip
);

    logic [WORD_BITS-1:0] addr;
    logic [WORD_BITS-1:0] mdin;
    logic [WORD_BITS-1:0] panel_addr;   // location shown on the panel
    logic                 panel_step;
    logic                 write_en;
    logic                 auto_index;
    opcode_t              opcode;

    pdp8_ram ram (
        .clk      (clk),
        .addr     (addr),
        .din      (mdin),
        .write_en (write_en),
        .dout     (mdout)
    );

    always_comb
    begin
        opcode     = opcode_t'(instruction[11:9]);
        auto_index = (ma[11:3] == AUTO_INDEX_PAGE);
        case (state)
            F0, F1, F2, F3: addr = pc;
            H0, H1, H2, H3: addr = panel_addr;   // holds mdout after examine
            default:        addr = ma;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ma          <= '0;
            instruction <= 12'o7000;   // nop
            isz_skip    <= 1'b0;
            write_en    <= 1'b0;
            panel_addr  <= '0;
            panel_step  <= 1'b0;
        end
        else
        begin
            write_en <= 1'b0;
            case (state)
                F0: ma <= pc;
                F1: instruction <= mdout;
                F3: if (opcode != OP_IOT && opcode != OP_OPR)
                    begin
                        ma <= page_addr(instruction, pc);
                    end
                D1: if (auto_index)
                    begin
                        write_en <= 1'b1;   // pointer written back at end of D2
                    end
                D2: ma <= auto_index ? mdout + 12'o0001 : mdout;
                E1: case (opcode)
                        OP_ISZ:
                        begin
                            write_en <= 1'b1;
                            isz_skip <= (mdout == 12'o7777);
                        end
                        OP_DCA, OP_JMS: write_en <= 1'b1;
                        default: ;
                    endcase
                E3: isz_skip <= 1'b0;
                H1: begin
                    panel_step <= 1'b0;
                    if (panel_load)
                    begin
                        ma         <= sr;
                        panel_addr <= sr;
                    end
                    else if (panel_deposit || panel_examine)
                    begin
                        panel_addr <= ma;
                        panel_step <= 1'b1;
                        write_en   <= panel_deposit;
                    end
                end
                H2: if (panel_step)
                    begin
                        ma <= ma + 12'o0001;
                    end
                default: ;
            endcase
        end
    end

    // write data
    always_ff @(posedge clk)
    begin
        case (state)
            D1: mdin <= mdout + 12'o0001;
            E1: case (opcode)
                    OP_ISZ: mdin <= mdout + 12'o0001;
                    OP_DCA: mdin <= ac;
                    OP_JMS: mdin <= pc;   // already points past the jms
                    default: ;
                endcase
            H1: mdin <= sr;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== pdp8_pkg.sv ====
`default_nettype none

package pdp8_pkg;

    localparam int WORD_BITS = 12;
    localparam int MEM_WORDS = 4096;                 // one 4K field

    localparam logic [8:0] AUTO_INDEX_PAGE = 9'o001; // 0010-0017

    // bit positions, numbered [11:0] so PDP bit 0 is index 11
    localparam int IND_BIT   = 8;
    localparam int PAGE_BIT  = 7;
    localparam int OPR_GROUP = 8;
    localparam int OPR_CLA   = 7;
    localparam int OPR_CMA   = 5;
    localparam int OPR_IAC   = 0;
    localparam int OPR_HLT   = 1;

    typedef enum logic [4:0] {
        F0, F1, F2, F3,
        D0, D1, D2, D3,
        E0, E1, E2, E3,
        H0, H1, H2, H3
    } major_state_t;

    typedef enum logic [2:0] {
        OP_AND, OP_TAD, OP_ISZ, OP_DCA, OP_JMS, OP_JMP, OP_IOT, OP_OPR
    } opcode_t;

    // page zero or current page of the instruction at pc
    function automatic logic [WORD_BITS-1:0] page_addr(
        input logic [WORD_BITS-1:0] instr,
        input logic [WORD_BITS-1:0] pc
    );
        if (instr[PAGE_BIT])
            return {pc[11:7], instr[6:0]};
        return {5'b00000, instr[6:0]};
    endfunction

endpackage

`default_nettype wire

// ==== pdp8_ram.sv ====
`default_nettype none

module pdp8_ram
    import pdp8_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic [WORD_BITS-1:0] addr,
    input  wire logic [WORD_BITS-1:0] din,
    input  wire logic                 write_en,
    output logic      [WORD_BITS-1:0] dout
);

    logic [WORD_BITS-1:0] mem [0:MEM_WORDS-1];

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            mem[addr] <= din;
        end
        dout <= mem[addr];   // old data on a same-cycle write
    end

endmodule

`default_nettype wire

// ==== pdp8_regs.sv ====
`default_nettype none

module pdp8_regs
    import pdp8_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire major_state_t         state,
    input  wire logic [WORD_BITS-1:0] instruction,
    input  wire logic [WORD_BITS-1:0] mdout,
    input  wire logic [WORD_BITS-1:0] ma,
    input  wire logic                 isz_skip,
    input  wire logic [WORD_BITS-1:0] sr,
    input  wire logic                 panel_load,
    output logic      [WORD_BITS-1:0] pc,
    output logic      [WORD_BITS-1:0] ac,
    output logic                      link,
    output logic                      halt_req
);

    opcode_t          opcode;
    logic             group2;
    logic             direct_jmp;
    logic [WORD_BITS-1:0] opr_ac;
    logic [WORD_BITS:0]   opr_sum;
    logic [WORD_BITS:0]   tad_sum;

    always_comb
    begin
        opcode     = opcode_t'(instruction[11:9]);
        group2     = instruction[OPR_GROUP];
        direct_jmp = (opcode == OP_JMP) && !instruction[IND_BIT];

        // group 1 order: cla, then cma, then iac
        opr_ac = instruction[OPR_CLA] ? '0 : ac;
        if (instruction[OPR_CMA])
            opr_ac = ~opr_ac;
        opr_sum = {1'b0, opr_ac} + {{WORD_BITS{1'b0}}, instruction[OPR_IAC]};

        tad_sum  = {1'b0, ac} + {1'b0, mdout};
        halt_req = (state == F3) && (opcode == OP_OPR) && group2 && instruction[OPR_HLT];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc   <= '0;
            ac   <= '0;
            link <= 1'b0;
        end
        else
        begin
            case (state)
                F3: begin
                    if (direct_jmp)
                        pc <= page_addr(instruction, pc);
                    else
                        pc <= pc + 12'o0001;
                    if (opcode == OP_OPR && !group2)
                    begin
                        ac   <= opr_sum[WORD_BITS-1:0];
                        link <= link ^ opr_sum[WORD_BITS];
                    end
                end
                D3: if (opcode == OP_JMP)
                    begin
                        pc <= ma;   // pointer loaded in D2
                    end
                E2: case (opcode)
                        OP_AND: ac <= ac & mdout;
                        OP_TAD:
                        begin
                            ac   <= tad_sum[WORD_BITS-1:0];
                            link <= link ^ tad_sum[WORD_BITS];
                        end
                        OP_DCA: ac <= '0;
                        default: ;
                    endcase
                E3: if (opcode == OP_JMS)
                        pc <= ma + 12'o0001;
                    else if (isz_skip)
                        pc <= pc + 12'o0001;
                H1: if (panel_load)
                    begin
                        pc <= sr;
                    end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== pdp8_state_seq.sv ====
`default_nettype none

module pdp8_state_seq
    import pdp8_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [WORD_BITS-1:0] instruction,
    input  wire logic                 run,
    input  wire logic                 halt,
    input  wire logic                 halt_req,
    input  wire logic                 load_addr,
    input  wire logic                 deposit,
    input  wire logic                 examine,
    output major_state_t              state,
    output logic                      running,
    output logic                      panel_load,
    output logic                      panel_deposit,
    output logic                      panel_examine
);

    opcode_t      opcode;
    logic         mem_ref;
    logic         defer;
    logic         exec;
    logic         in_halt;
    logic         run_req;
    logic         load_req;
    logic         dep_req;
    logic         exam_req;
    major_state_t done_state;
    major_state_t next_state;

    always_comb
    begin
        opcode  = opcode_t'(instruction[11:9]);
        mem_ref = (opcode != OP_IOT) && (opcode != OP_OPR);
        defer   = mem_ref && instruction[IND_BIT];
        exec    = mem_ref && (opcode != OP_JMP);
        in_halt = state inside {H0, H1, H2, H3};

        panel_load    = (state == H1) && load_req;
        panel_deposit = (state == H1) && dep_req;
        panel_examine = (state == H1) && exam_req;

        // where to go once the instruction is finished
        done_state = (running && !halt && !halt_req) ? F0 : H0;

        case (state)
            F0: next_state = F1;
            F1: next_state = F2;
            F2: next_state = F3;
            F3: next_state = defer ? D0 : (exec ? E0 : done_state);
            D0: next_state = D1;
            D1: next_state = D2;
            D2: next_state = D3;
            D3: next_state = (opcode == OP_JMP) ? done_state : E0;
            E0: next_state = E1;
            E1: next_state = E2;
            E2: next_state = E3;
            E3: next_state = done_state;
            H0: next_state = H1;
            H1: next_state = H2;
            H2: next_state = H3;
            H3: next_state = ((run_req || run) && !halt) ? F0 : H0;
            default: next_state = H0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= H0;
            running  <= 1'b0;
            run_req  <= 1'b0;
            load_req <= 1'b0;
            dep_req  <= 1'b0;
            exam_req <= 1'b0;
        end
        else
        begin
            state <= next_state;

            if (state == H3 && next_state == F0)
                running <= 1'b1;
            else if (halt || halt_req)
                running <= 1'b0;   // instruction still completes

            if (halt || state == H3)
                run_req <= 1'b0;
            else if (run && in_halt)
                run_req <= 1'b1;

            // a new pulse wins over the H1 clear
            if (in_halt && load_addr)
                load_req <= 1'b1;
            else if (state == H1)
                load_req <= 1'b0;
            if (in_halt && deposit)
                dep_req <= 1'b1;
            else if (state == H1)
                dep_req <= 1'b0;
            if (in_halt && examine)
                exam_req <= 1'b1;
            else if (state == H1)
                exam_req <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== pdp8_tb.sv ====
`default_nettype none

module pdp8_tb
    import pdp8_pkg::*;
();

    localparam int PERIOD      = 4;
    localparam int PANEL_OPS   = 110;   // panel presses over all tests
    localparam int INSTRS      = 40;    // instructions run, halt loop excluded
    localparam int LOOP_CYCLES = 40;
    localparam int LIMIT = 2 * PERIOD * (8 * PANEL_OPS + 12 * INSTRS + 2 * LOOP_CYCLES + 2);

    logic        clk;
    logic        reset;
    logic [11:0] sr;
    logic        load_addr;
    logic        deposit;
    logic        examine;
    logic        run;
    logic        halt;

    wire logic [11:0]  pc;
    wire logic [11:0]  ac;
    wire logic         link;
    wire logic [11:0]  ma;
    wire logic [11:0]  mdout;
    wire major_state_t state;
    wire logic         running;

    logic [11:0] ref_mem [0:4095];   // expected memory contents
    logic [11:0] m_ac;
    logic [11:0] m_pc;
    logic        m_link;
    logic [11:0] m_ma;               // next location the panel acts on
    logic [11:0] prog [$];
    logic [31:0] lcg;

    pdp8_core UUT (
        .clk       (clk),
        .reset     (reset),
        .sr        (sr),
        .load_addr (load_addr),
        .deposit   (deposit),
        .examine   (examine),
        .run       (run),
        .halt      (halt),
        .pc        (pc),
        .ac        (ac),
        .link      (link),
        .ma        (ma),
        .mdout     (mdout),
        .state     (state),
        .running   (running)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [11:0] next_rand();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg[27:16];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] want);
        assert (got === want)
        else
            abort_run($sformatf("[ERROR] t=%0t %s expected %o got %o",
                                $time, name, want, got));
    endtask

    task automatic wait_h0();
        @(negedge clk);
        while (state != H0)
            @(negedge clk);
    endtask

    // one-cycle panel pulse at H0, back at the next H0 when done
    task automatic press(ref logic key);
        wait_h0();
        key = 1'b1;
        @(negedge clk);
        key = 1'b0;
        wait_h0();
    endtask

    task automatic load_address(input logic [11:0] addr);
        sr = addr;
        press(load_addr);
        m_ma = addr;
        check_value("ma", ma, addr);
        check_value("pc", pc, addr);
    endtask

    task automatic deposit_word(input logic [11:0] word);
        sr = word;
        press(deposit);
        ref_mem[m_ma] = word;
        m_ma = m_ma + 12'o1;
        check_value("ma", ma, m_ma);
    endtask

    task automatic examine_next();
        press(examine);
        check_value("mdout", mdout, ref_mem[m_ma]);
        m_ma = m_ma + 12'o1;
        check_value("ma", ma, m_ma);
    endtask

    task automatic examine_at(input logic [11:0] addr);
        load_address(addr);
        examine_next();
    endtask

    task automatic poke(input logic [11:0] addr, input logic [11:0] word);
        load_address(addr);
        deposit_word(word);
    endtask

    task automatic store_program(input logic [11:0] start);
        load_address(start);
        foreach (prog[i])
            deposit_word(prog[i]);
    endtask

    // instruction set model, runs from start up to the HLT
    task automatic model_run(input logic [11:0] start);
        logic [11:0] ir;
        logic [11:0] ea;
        logic        carry;
        logic        halted;
        int          steps;
        m_pc = start;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 64)
        begin
            ir = ref_mem[m_pc];
            ea = ir[7] ? {m_pc[11:7], ir[6:0]} : {5'o0, ir[6:0]};
            m_pc = m_pc + 12'o1;
            steps++;
            if (ir[8] && ir[11:9] < 3'o6)
            begin
                if (ea >= 12'o0010 && ea <= 12'o0017)
                    ref_mem[ea] = ref_mem[ea] + 12'o1;   // auto-index before use
                ea = ref_mem[ea];
            end
            case (opcode_t'(ir[11:9]))
                OP_AND: m_ac = m_ac & ref_mem[ea];
                OP_TAD:
                begin
                    {carry, m_ac} = m_ac + ref_mem[ea];
                    m_link = m_link ^ carry;
                end
                OP_ISZ:
                begin
                    ref_mem[ea] = ref_mem[ea] + 12'o1;
                    if (ref_mem[ea] == 12'o0000)
                        m_pc = m_pc + 12'o1;
                end
                OP_DCA:
                begin
                    ref_mem[ea] = m_ac;
                    m_ac = 12'o0000;
                end
                OP_JMS:
                begin
                    ref_mem[ea] = m_pc;
                    m_pc = ea + 12'o1;
                end
                OP_JMP: m_pc = ea;
                OP_OPR:
                    if (!ir[8])
                    begin
                        if (ir[7])
                            m_ac = 12'o0000;
                        if (ir[5])
                            m_ac = ~m_ac;
                        if (ir[0])
                        begin
                            {carry, m_ac} = m_ac + 12'o1;
                            m_link = m_link ^ carry;
                        end
                    end
                    else if (ir[1])
                        halted = 1'b1;
                default: ;   // iot
            endcase
        end
        if (!halted)
            abort_run("reference model found no halt within its step limit");
    endtask

    task automatic run_program(input logic [11:0] start);
        load_address(start);
        model_run(start);
        press(run);
        check_value("running", running, 1'b0);
        check_value("pc", pc, m_pc);
        check_value("ac", ac, m_ac);
        check_value("link", link, m_link);
    endtask

    always @(negedge clk)
        if (UUT.core_checks.fail_count != 0)
            abort_run("a bound assertion on the core failed");

    initial
    begin
        #(LIMIT);
        abort_run("watchdog expired before the tests finished");
    end

    initial
    begin
        lcg = 32'd4433;
        reset = 1'b1;
        sr = 12'o0000;
        load_addr = 1'b0;
        deposit = 1'b0;
        examine = 1'b0;
        run = 1'b0;
        halt = 1'b0;
        m_ac = 12'o0000;
        m_link = 1'b0;
        m_pc = 12'o0000;
        m_ma = 12'o0000;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // panel deposit, then examine back
        load_address(12'o2000);
        for (int i = 0; i < 8; i++)
            deposit_word(next_rand());
        load_address(12'o2000);
        for (int i = 0; i < 8; i++)
            examine_next();

        // cla, tad, tad, dca, hlt
        prog = '{12'o7200, 12'o1206, 12'o1207, 12'o3210, 12'o7402,
                 12'o0000, next_rand(), next_rand(), 12'o0000};
        store_program(12'o0200);
        run_program(12'o0200);
        examine_at(12'o0210);

        // isz on 7777 skips, on a smaller value it does not
        prog = '{12'o2205, 12'o7402, 12'o7402, 12'o0000, 12'o0000, 12'o7777};
        store_program(12'o0400);
        run_program(12'o0400);
        check_value("pc", pc, 12'o0403);
        examine_at(12'o0405);
        poke(12'o0405, next_rand() & 12'o3777);
        run_program(12'o0400);
        check_value("pc", pc, 12'o0402);
        examine_at(12'o0405);

        // tad i 0010 auto-indexes, tad i 0020 does not
        poke(12'o0010, 12'o1077);
        poke(12'o0020, 12'o1200);
        poke(12'o1077, next_rand());
        poke(12'o1100, next_rand());
        poke(12'o1200, next_rand());
        prog = '{12'o7200, 12'o1410, 12'o1420, 12'o7402};
        store_program(12'o0600);
        run_program(12'o0600);
        examine_at(12'o0010);
        examine_at(12'o0020);

        // jms to 1010, return by jmp i 1010
        prog = '{12'o7200, 12'o4210, 12'o1213, 12'o7402, 12'o0000, 12'o0000, 12'o0000,
                 12'o0000, 12'o0000, 12'o1214, 12'o5610, next_rand(), next_rand()};
        store_program(12'o1000);
        run_program(12'o1000);
        examine_at(12'o1010);

        // cma iac, then an iac/jmp loop at 1410
        prog = '{12'o7200, 12'o1204, 12'o7041, 12'o7402, next_rand(), 12'o0000,
                 12'o0000, 12'o0000, 12'o7001, 12'o5210};
        store_program(12'o1400);
        run_program(12'o1400);
        load_address(12'o1410);
        fork
            press(run);
            begin
                while (!running)
                    @(negedge clk);
                repeat (LOOP_CYCLES) @(negedge clk);
                halt = 1'b1;
                @(negedge clk);
                halt = 1'b0;
            end
        join
        check_value("running", running, 1'b0);
        assert (pc == 12'o1410 || pc == 12'o1411)
        else
            abort_run("halt pulse left pc outside the loop");

        if (UUT.core_checks.fail_count == 0)
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
            abort_run("bound assertions on the core reported errors");
    end

endmodule

`default_nettype wire
